// File: verilog/mlsdDataPkg.sv
package mlsdDataPkg;

	// signed received code from the slicer front end.
	parameter int codeWidth = 8;

	// signed channel response tap.
	parameter int tapWidth = 8;

	// unsigned error energy, wide enough for squared 10-bit errors summed.
	parameter int energyWidth = 20;

	// upper limit on the number of channel taps.
	parameter int maxTaps = 8;

	// host tap address.
	parameter int tapAddrWidth = $clog2(maxTaps);

endpackage

// File: verilog/mlsdCtrlPkg.sv
package mlsdCtrlPkg;

	// progress of the code window after reset.
	typedef enum logic [1:0] {
		fsIdle,
		fsFill,
		fsRun
	} fillState;

	// host tap port command.
	typedef enum logic [1:0] {
		opNone,
		opWrite,
		opClear
	} tapOp;

endpackage

// File: verilog/tapRegFile.sv
`timescale 1ns/100ps

module tapRegFile
	import mlsdDataPkg::*;
	import mlsdCtrlPkg::*;
#(
	parameter int estDepth = 3
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  mlsdCtrlPkg::tapOp          tapOp,
	input  logic [tapAddrWidth-1:0]    tapAddr,
	input  logic signed [tapWidth-1:0] tapData,
	output logic signed [tapWidth-1:0] taps [estDepth]
);

	// a write to an address with no tap behind it is dropped.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int k = 0; k < estDepth; k++) begin
				taps[k] <= '0;
			end
		end else begin
			case (tapOp)
				opWrite: begin
					for (int k = 0; k < estDepth; k++) begin
						if (tapAddr == tapAddrWidth'(k)) begin
							taps[k] <= tapData;
						end
					end
				end
				opClear: begin
					for (int k = 0; k < estDepth; k++) begin
						taps[k] <= '0;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: verilog/codeWindow.sv
`timescale 1ns/100ps

module codeWindow
	import mlsdDataPkg::*;
	import mlsdCtrlPkg::*;
#(
	parameter int numChannels = 4,
	parameter int estDepth    = 3,
	parameter int seqLength   = 2
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        codesValid,
	input  logic signed [codeWidth-1:0] codes [numChannels],
	input  logic [numChannels-1:0]      estBits,
	output logic signed [codeWidth-1:0] winCodes [numChannels][seqLength],
	output logic [estDepth+seqLength-2:0] winBits [numChannels],
	output logic                        centreValid
);

	// whole words needed before and after the centre word.
	localparam int numPast   = (estDepth - 1 + numChannels - 1) / numChannels;
	localparam int numFuture = (seqLength - 1 + numChannels - 1) / numChannels;
	localparam int bufDepth  = numPast + 1 + numFuture;
	localparam int winLen    = estDepth + seqLength - 1;
	localparam int cntWidth  = $clog2(bufDepth + 1);

	// index 0 is the oldest word. codes are only kept from the centre on.
	logic signed [codeWidth-1:0] codeBuf [numFuture+1][numChannels];
	logic [numChannels-1:0]      bitBuf [bufDepth];

	logic signed [codeWidth-1:0]       codeFlat [(numFuture+1)*numChannels];
	logic [bufDepth*numChannels-1:0]   bitFlat;

	fillState              state;
	logic [cntWidth-1:0]   fillCnt;

	////////////////////////////////////////////////////////////////////////////
	// word buffers and fill tracking.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state       <= fsIdle;
			fillCnt     <= '0;
			centreValid <= 1'b0;
			codeBuf     <= '{default: '0};
			bitBuf      <= '{default: '0};
		end else begin
			// the new centre is real once the future words are in.
			centreValid <= codesValid && (state == fsRun || int'(fillCnt) >= numFuture);
			if (codesValid) begin
				for (int i = 0; i < numFuture; i++) begin
					codeBuf[i] <= codeBuf[i+1];
				end
				codeBuf[numFuture] <= codes;
				for (int i = 0; i < bufDepth - 1; i++) begin
					bitBuf[i] <= bitBuf[i+1];
				end
				bitBuf[bufDepth-1] <= estBits;
				case (state)
					fsIdle, fsFill: begin
						fillCnt <= fillCnt + 1'b1;
						state   <= (int'(fillCnt) + 1 >= bufDepth) ? fsRun : fsFill;
					end
					default: begin
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// per-sample windows.
	////////////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w <= numFuture; w++) begin : genCodeFlat
		for (genvar c = 0; c < numChannels; c++) begin : genLane
			assign codeFlat[w*numChannels+c] = codeBuf[w][c];
		end
	end

	for (genvar w = 0; w < bufDepth; w++) begin : genBitFlat
		assign bitFlat[w*numChannels +: numChannels] = bitBuf[w];
	end

	// bit m of a lane window sits estDepth-1 samples before the lane sample.
	for (genvar l = 0; l < numChannels; l++) begin : genWin
		for (genvar j = 0; j < seqLength; j++) begin : genCode
			assign winCodes[l][j] = codeFlat[l+j];
		end
		assign winBits[l] = bitFlat[numPast*numChannels + l - (estDepth - 1) +: winLen];
	end

endmodule

// File: verilog/hypothesisEnergy.sv
`timescale 1ns/100ps

module hypothesisEnergy
	import mlsdDataPkg::*;
#(
	parameter int numChannels = 4,
	parameter int estDepth    = 3,
	parameter int seqLength   = 2,
	parameter int nbit        = 2
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          centreValid,
	input  logic signed [codeWidth-1:0]   winCodes [numChannels][seqLength],
	input  logic [estDepth+seqLength-2:0] winBits [numChannels],
	input  logic signed [tapWidth-1:0]    taps [estDepth],
	output logic [energyWidth-1:0]        energies [numChannels][2**nbit],
	output logic                          energyValid
);

	localparam int numHyp = 2 ** nbit;
	localparam int winLen = estDepth + seqLength - 1;

	// energies follow the window by one edge.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			energyValid <= 1'b0;
		end else begin
			energyValid <= centreValid;
		end
	end

	for (genvar l = 0; l < numChannels; l++) begin : genLane
		for (genvar h = 0; h < numHyp; h++) begin : genHyp
			localparam logic [nbit-1:0] hypVal = nbit'(h);

			logic [winLen-1:0]      hypBits;
			logic [energyWidth-1:0] energyNext;

			// hypothesis bits replace the tentative bits from the centre sample on.
			for (genvar m = 0; m < winLen; m++) begin : genBit
				if (m >= estDepth - 1 && m < estDepth - 1 + nbit) begin : genSub
					assign hypBits[m] = hypVal[m-(estDepth-1)];
				end else begin : genKeep
					assign hypBits[m] = winBits[l][m];
				end
			end

			always_comb begin : calcEnergy
				int expCode;
				int errCode;
				int sum;
				sum = 0;
				for (int j = 0; j < seqLength; j++) begin
					expCode = 0;
					// bit 1 is symbol +1, bit 0 is symbol -1.
					for (int k = 0; k < estDepth; k++) begin
						if (hypBits[estDepth-1+j-k]) begin
							expCode += int'(taps[k]);
						end else begin
							expCode -= int'(taps[k]);
						end
					end
					errCode = int'(winCodes[l][j]) - expCode;
					sum += errCode * errCode;
				end
				energyNext = energyWidth'(sum);
			end

			always_ff @(posedge clk) begin
				energies[l][h] <= energyNext;
			end
		end
	end

endmodule

// File: verilog/minEnergySelect.sv
`timescale 1ns/100ps

module minEnergySelect
	import mlsdDataPkg::*;
#(
	parameter int numChannels = 4,
	parameter int nbit        = 2
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   energyValid,
	input  logic [energyWidth-1:0] energies [numChannels][2**nbit],
	output logic [numChannels-1:0] predictBits,
	output logic                   predictValid
);

	localparam int numHyp = 2 ** nbit;

	logic [nbit-1:0] bestIdx [numChannels];

	// strict compare, so equal energies keep the lower hypothesis.
	always_comb begin
		logic [energyWidth-1:0] bestEnergy;
		for (int l = 0; l < numChannels; l++) begin
			bestIdx[l] = '0;
			bestEnergy = energies[l][0];
			for (int h = 1; h < numHyp; h++) begin
				if (energies[l][h] < bestEnergy) begin
					bestEnergy = energies[l][h];
					bestIdx[l] = nbit'(h);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			predictValid <= 1'b0;
		end else begin
			predictValid <= energyValid;
		end
	end

	always_ff @(posedge clk) begin
		if (energyValid) begin
			for (int l = 0; l < numChannels; l++) begin
				predictBits[l] <= bestIdx[l][0];
			end
		end
	end

endmodule

// File: verilog/flatMlsd.sv
`timescale 1ns/100ps

module flatMlsd
	import mlsdDataPkg::*;
#(
	parameter int numChannels = 4,
	parameter int estDepth    = 3,
	parameter int seqLength   = 2,
	parameter int nbit        = 2
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  mlsdCtrlPkg::tapOp           tapOp,
	input  logic [tapAddrWidth-1:0]     tapAddr,
	input  logic signed [tapWidth-1:0]  tapData,
	input  logic                        codesValid,
	input  logic signed [codeWidth-1:0] codes [numChannels],
	input  logic [numChannels-1:0]      estBits,
	output logic [numChannels-1:0]      predictBits,
	output logic                        predictValid
);

	localparam int numHyp = 2 ** nbit;
	localparam int winLen = estDepth + seqLength - 1;

	logic signed [tapWidth-1:0]  taps [estDepth];
	logic signed [codeWidth-1:0] winCodes [numChannels][seqLength];
	logic [winLen-1:0]           winBits [numChannels];
	logic                        centreValid;
	logic [energyWidth-1:0]      energies [numChannels][numHyp];
	logic                        energyValid;

	tapRegFile #(
		.estDepth(estDepth)
	) tapRegFile0 (
		.clk    (clk),
		.rstN   (rstN),
		.tapOp  (tapOp),
		.tapAddr(tapAddr),
		.tapData(tapData),
		.taps   (taps)
	);

	codeWindow #(
		.numChannels(numChannels),
		.estDepth   (estDepth),
		.seqLength  (seqLength)
	) codeWindow0 (
		.clk        (clk),
		.rstN       (rstN),
		.codesValid (codesValid),
		.codes      (codes),
		.estBits    (estBits),
		.winCodes   (winCodes),
		.winBits    (winBits),
		.centreValid(centreValid)
	);

	hypothesisEnergy #(
		.numChannels(numChannels),
		.estDepth   (estDepth),
		.seqLength  (seqLength),
		.nbit       (nbit)
	) hypothesisEnergy0 (
		.clk        (clk),
		.rstN       (rstN),
		.centreValid(centreValid),
		.winCodes   (winCodes),
		.winBits    (winBits),
		.taps       (taps),
		.energies   (energies),
		.energyValid(energyValid)
	);

	minEnergySelect #(
		.numChannels(numChannels),
		.nbit       (nbit)
	) minEnergySelect0 (
		.clk         (clk),
		.rstN        (rstN),
		.energyValid (energyValid),
		.energies    (energies),
		.predictBits (predictBits),
		.predictValid(predictValid)
	);

endmodule

// File: tests/mlsdModel.svh
`ifndef MLSD_MODEL_SVH
`define MLSD_MODEL_SVH

// sample n of a run is word times numChannels plus lane.
localparam int maxSamples = 512;

int unsigned lcgState = 40;
int          mTaps [estDepth];
bit          trueBit [maxSamples];
bit          estBit [maxSamples];
int          rxCode [maxSamples];

function automatic int unsigned lcgNext();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return (lcgState >> 16) & 32'h7fff;
endfunction

// bits before the stream are 0, so the symbol there is -1.
function automatic int trueSymbol(int m);
	return (m < 0) ? -1 : 2 * int'(trueBit[m]) - 1;
endfunction

function automatic int channelCode(int n);
	int sum;
	sum = 0;
	for (int k = 0; k < estDepth; k++) begin
		sum += mTaps[k] * trueSymbol(n - k);
	end
	return sum;
endfunction

// symbol at position m when hypothesis h is tried for sample n.
function automatic int hypSymbol(int m, int n, int h);
	int b;
	if (m >= n && m < n + nbit) begin
		b = (h >> (m - n)) & 1;
	end else if (m < 0) begin
		b = 0;
	end else begin
		b = int'(estBit[m]);
	end
	return 2 * b - 1;
endfunction

function automatic logic predictSample(int n);
	int best;
	int bestH;
	int energy;
	int expCode;
	int err;
	best = -1;
	bestH = 0;
	for (int h = 0; h < 2 ** nbit; h++) begin
		energy = 0;
		for (int j = 0; j < seqLength; j++) begin
			expCode = 0;
			for (int k = 0; k < estDepth; k++) begin
				expCode += mTaps[k] * hypSymbol(n + j - k, n, h);
			end
			err = rxCode[n + j] - expCode;
			energy += err * err;
		end
		// first strict minimum, so ties keep the lower hypothesis.
		if (best < 0 || energy < best) begin
			best = energy;
			bestH = h;
		end
	end
	return bestH[0];
endfunction

function automatic logic [numChannels-1:0] predictWord(int w);
	logic [numChannels-1:0] word;
	for (int l = 0; l < numChannels; l++) begin
		word[l] = predictSample(w * numChannels + l);
	end
	return word;
endfunction

function automatic bit anyTapSet();
	bit found;
	found = 1'b0;
	for (int k = 0; k < estDepth; k++) begin
		if (mTaps[k] != 0) begin
			found = 1'b1;
		end
	end
	return found;
endfunction

`endif

// File: tests/mlsdTb.sv
`timescale 1ns/100ps

module mlsdTb
	import mlsdDataPkg::*;
	import mlsdCtrlPkg::*;
();

	localparam int numChannels = 4;
	localparam int estDepth    = 3;
	localparam int seqLength   = 2;
	localparam int nbit        = 2;
	localparam int numFuture   = (seqLength - 1 + numChannels - 1) / numChannels;
	localparam int totalWords  = numFuture + 4 * 64 + 16;
	localparam int cycleLimit  = 2 * totalWords + 200;

	`include "mlsdModel.svh"

	logic                        clk;
	logic                        rstN;
	tapOp                        tapCmd;
	logic [tapAddrWidth-1:0]     tapAddr;
	logic signed [tapWidth-1:0]  tapData;
	logic                        codesValid;
	logic signed [codeWidth-1:0] codes [numChannels];
	logic [numChannels-1:0]      estBits;
	logic [numChannels-1:0]      predictBits;
	logic                        predictValid;

	logic [numChannels-1:0] expQ [$];
	logic [numChannels-1:0] expWord;
	int cycleCnt;
	int errCount;
	int checkCount;
	int predCount;
	int testNum;

	flatMlsd #(
		.numChannels(numChannels),
		.estDepth   (estDepth),
		.seqLength  (seqLength),
		.nbit       (nbit)
	) dut0 (
		.clk         (clk),
		.rstN        (rstN),
		.tapOp       (tapCmd),
		.tapAddr     (tapAddr),
		.tapData     (tapData),
		.codesValid  (codesValid),
		.codes       (codes),
		.estBits     (estBits),
		.predictBits (predictBits),
		.predictValid(predictValid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// checker and cycle limit.
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycleCnt++;
		if (cycleCnt > cycleLimit) begin
			$display("run stopped after %0d cycles without finishing", cycleCnt);
			$display("CHECKS FAILED");
			$finish;
		end else if (predictValid) begin
			if (expQ.size() == 0) begin
				$display("prediction arrived with no word waiting for it");
				errCount++;
			end else begin
				expWord = expQ.pop_front();
				checkCount++;
				predCount++;
				if (predictBits !== expWord) begin
					$display("FAILED predictBits expected %h actual %h", expWord, predictBits);
					errCount++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks.
	////////////////////////////////////////////////////////////////////////////

	task automatic resetDut();
		@(posedge clk);
		rstN <= 1'b0;
		codesValid <= 1'b0;
		tapCmd <= opNone;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		for (int k = 0; k < estDepth; k++) begin
			mTaps[k] = 0;
		end
	endtask

	task automatic tapCommand(input tapOp op, input int addr, input int value);
		@(posedge clk);
		tapCmd <= op;
		tapAddr <= tapAddrWidth'(addr);
		tapData <= tapWidth'(value);
		if (op == opWrite && addr < estDepth) begin
			mTaps[addr] = value;
		end
		if (op == opClear) begin
			for (int k = 0; k < estDepth; k++) begin
				mTaps[k] = 0;
			end
		end
		@(posedge clk);
		tapCmd <= opNone;
	endtask

	task automatic writeTriangle();
		tapCommand(opWrite, 0, 8);
		tapCommand(opWrite, 1, 16);
		tapCommand(opWrite, 2, 8);
	endtask

	task automatic runPhase(input string name, input int nWords, input bit flip,
			input int noise, input bit gaps);
		int n;
		int errStart;
		int waitCnt;
		logic [numChannels-1:0] modelWord;
		logic [numChannels-1:0] trueWord;
		errStart = errCount;
		predCount = 0;
		for (int w = 0; w < nWords; w++) begin
			@(posedge clk);
			if (gaps && lcgNext() % 4 == 0) begin
				codesValid <= 1'b0;
				@(posedge clk);
			end
			for (int l = 0; l < numChannels; l++) begin
				n = w * numChannels + l;
				trueBit[n] = 1'(lcgNext());
				estBit[n] = (flip && lcgNext() % 4 == 0) ? !trueBit[n] : trueBit[n];
				rxCode[n] = channelCode(n);
				if (noise > 0) begin
					rxCode[n] += int'(lcgNext() % (2 * noise + 1)) - noise;
				end
				codes[l] <= codeWidth'(rxCode[n]);
				estBits[l] <= estBit[n];
			end
			codesValid <= 1'b1;
			// word w completes the window of the word numFuture before it.
			if (w >= numFuture) begin
				modelWord = predictWord(w - numFuture);
				for (int l = 0; l < numChannels; l++) begin
					trueWord[l] = trueBit[(w - numFuture) * numChannels + l];
				end
				if (!flip && noise == 0 && modelWord != trueWord) begin
					$display("model prediction %h differs from true bits %h", modelWord, trueWord);
					errCount++;
				end
				// with every tap at zero all hypotheses tie and hypothesis 0 wins.
				if (!anyTapSet()) begin
					expQ.push_back({numChannels{1'b0}});
				end else begin
					expQ.push_back(modelWord);
				end
			end
		end
		@(posedge clk);
		codesValid <= 1'b0;
		waitCnt = 0;
		while (expQ.size() > 0 && waitCnt < 20) begin
			@(posedge clk);
			waitCnt++;
		end
		repeat (4) @(posedge clk);
		if (expQ.size() > 0) begin
			$display("%0d predictions never arrived", expQ.size());
			errCount++;
			expQ.delete();
		end
		if (predCount != nWords - numFuture) begin
			$display("expected %0d predictions but got %0d", nWords - numFuture, predCount);
			errCount++;
		end
		testNum++;
		$display("test %0d %s: %0d predictions, %s", testNum, name, predCount,
			(errCount == errStart) ? "ok" : "errors");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence.
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rstN <= 1'b0;
		tapCmd <= opNone;
		tapAddr <= '0;
		tapData <= '0;
		codesValid <= 1'b0;
		codes <= '{default: '0};
		estBits <= '0;

		resetDut();
		runPhase("reset and fill", numFuture, 1'b0, 0, 1'b0);

		resetDut();
		writeTriangle();
		runPhase("noiseless triangle", 64, 1'b0, 0, 1'b0);

		resetDut();
		writeTriangle();
		runPhase("flipped estBits", 64, 1'b1, 0, 1'b0);

		resetDut();
		writeTriangle();
		runPhase("noise and gaps", 64, 1'b1, 3, 1'b1);

		// tap 2 stays cleared, address 5 has no tap behind it.
		resetDut();
		writeTriangle();
		tapCommand(opClear, 0, 0);
		tapCommand(opWrite, 0, int'(lcgNext() % 31) - 15);
		tapCommand(opWrite, 1, int'(lcgNext() % 31) - 15);
		tapCommand(opWrite, 5, 99);
		runPhase("cleared and random taps", 64, 1'b1, 3, 1'b0);

		resetDut();
		runPhase("zero taps", 16, 1'b1, 3, 1'b0);

		$display("%0d tests, %0d predictions checked, %0d errors", testNum, checkCount,
			errCount);
		if (errCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+tests
verilog/mlsdDataPkg.sv
verilog/mlsdCtrlPkg.sv
verilog/tapRegFile.sv
verilog/codeWindow.sv
verilog/hypothesisEnergy.sv
verilog/minEnergySelect.sv
verilog/flatMlsd.sv
tests/mlsdTb.sv

// File: Makefile
# Verilator build and run for the MLSD testbench.

SOURCES := sim.f $(wildcard verilog/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

obj_dir/VmlsdTb: $(SOURCES)
	verilator --binary -j 0 --top-module mlsdTb -f sim.f -o VmlsdTb

run: obj_dir/VmlsdTb
	./obj_dir/VmlsdTb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
